// File: Bender.yml
package:
  name: axil_spi_writer

sources:
  - files:
      - design/spiWriterPkg.sv
      - design/axilRegFront.sv
      - design/spiWordStore.sv
      - design/spiShifter.sv
      - design/axilSpiWriter.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/spiWriterTb.sv

// File: design/axilRegFront.sv
// AXI4-Lite slave front end used by the serial writer top to commit writes to the word store and serve reads
`timescale 1ns/1ps

module axilRegFront
  import spiWriterPkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,         // synchronous active low reset

  // write address channel
  input  axiAddrT awaddr,
  input  logic    awvalid,
  output logic    awready,
  // write data channel
  input  axiDataT wdata,
  input  logic    wvalid,
  output logic    wready,
  // write response channel
  output axiRespT bresp,
  output logic    bvalid,
  input  logic    bready,
  // read address channel
  input  axiAddrT araddr,
  input  logic    arvalid,
  output logic    arready,
  // read data channel
  output axiDataT rdata,
  output axiRespT rresp,
  output logic    rvalid,
  input  logic    rready,

  // word store side
  input  axiDataT word0,           // readback of word 0
  input  axiDataT word1,           // readback of word 1
  input  logic    busy,            // shifter working
  input  logic    slotsCleared,    // shift finished so wready reopens
  output logic    storeWrite,      // one cycle commit strobe
  output logic    storeSelect,     // high selects word 1
  output axiDataT storeData
);

  axiAddrT waddrReg;               // latched write address
  axiAddrT raddrReg;               // latched read address
  axiDataT wdataReg;               // latched write data
  axiDataT rdataReg;
  axiDataT readMux;                // selected readback value
  logic    awreadyReg;
  logic    wreadyReg;
  logic    bvalidReg;
  logic    arreadyReg;
  logic    rvalidReg;
  logic    dataSeen;               // data beat taken before its address
  logic    awHandshake;
  logic    wHandshake;
  logic    arHandshake;

  assign awHandshake = awvalid & awreadyReg;
  assign wHandshake  = wvalid & wreadyReg;
  assign arHandshake = arvalid & arreadyReg;

  // all channel outputs come straight from registers
  assign awready = awreadyReg;
  assign wready  = wreadyReg;
  assign bvalid  = bvalidReg;
  assign arready = arreadyReg;
  assign rvalid  = rvalidReg;
  assign rdata   = rdataReg;
  assign bresp   = respOkay;
  assign rresp   = respOkay;

  // commit happens when the master takes the response
  assign storeWrite  = bvalidReg & bready;
  assign storeSelect = waddrReg[regIndexLsb];  // offset 4 -> word 1
  assign storeData   = wdataReg;

  //////////////////////////////
  // address and data latches
  //////////////////////////////
  always_ff @(posedge aclk)
  begin
    if (awHandshake)
      waddrReg <= awaddr;
    if (wHandshake)
      wdataReg <= wdata;
    if (arHandshake)
      raddrReg <= araddr;
  end

  //////////////////////////////
  // write channels
  //////////////////////////////
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awreadyReg <= 1'b1;          // ready for an address
      wreadyReg  <= 1'b1;          // ready for data
      bvalidReg  <= 1'b0;
      dataSeen   <= 1'b0;
    end
    else
    begin
      if (slotsCleared)
        wreadyReg <= 1'b1;         // previous word has gone out

      if (awHandshake)
        awreadyReg <= 1'b0;

      if (wHandshake)
      begin
        wreadyReg <= 1'b0;         // held shut until the shift is done
        dataSeen  <= 1'b1;
      end

      // address and data may arrive in either order or together
      if ((awHandshake && (wHandshake || dataSeen)) || (!awreadyReg && wHandshake))
        bvalidReg <= 1'b1;

      if (storeWrite)
      begin
        bvalidReg  <= 1'b0;
        awreadyReg <= 1'b1;        // next address welcome while data waits
        dataSeen   <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // read channels
  //////////////////////////////
  always_comb
  begin
    case (raddrReg[regIndexMsb:regIndexLsb])
      regWord0:  readMux = word0;
      regWord1:  readMux = word1;
      regStatus: readMux = {{(axiDataWidth-1){1'b0}}, busy};
      default:   readMux = '0;     // unmapped index reads zero
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      arreadyReg <= 1'b1;
      rvalidReg  <= 1'b0;
      rdataReg   <= '0;
    end
    else
    begin
      if (arHandshake)
        arreadyReg <= 1'b0;        // one read at a time

      // data taken once per read and held until the master accepts it
      if (!arreadyReg && !rvalidReg)
      begin
        rvalidReg <= 1'b1;
        rdataReg  <= readMux;
      end

      // read done so clear data and take the next address
      if (rvalidReg && rready)
      begin
        rvalidReg  <= 1'b0;
        arreadyReg <= 1'b1;
        rdataReg   <= '0;
      end
    end
  end

endmodule

// File: design/axilSpiWriter.sv
// top level of the AXI4-Lite serial writer; ties the bus front end, word store and shifter together
`timescale 1ns/1ps

module axilSpiWriter
  import spiWriterPkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,

  // AXI4-Lite slave
  input  axiAddrT awaddr,
  input  logic    awvalid,
  output logic    awready,
  input  axiDataT wdata,
  input  logic    wvalid,
  output logic    wready,
  output axiRespT bresp,
  output logic    bvalid,
  input  logic    bready,
  input  axiAddrT araddr,
  input  logic    arvalid,
  output logic    arready,
  output axiDataT rdata,
  output axiRespT rresp,
  output logic    rvalid,
  input  logic    rready,

  // serial pins
  output logic    serialClk,
  output logic    serialData,
  output logic    load0,
  output logic    load1
);

  axiDataT word0;                  // stored words, to shifter and readback
  axiDataT word1;
  axiDataT storeData;
  logic    storeWrite;
  logic    storeSelect;
  logic    slotsCleared;
  logic    pending0;
  logic    pending1;
  logic    shiftDone;
  logic    busy;

  axilRegFront front (
    .aclk, .aresetn,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .word0, .word1, .busy, .slotsCleared,
    .storeWrite, .storeSelect, .storeData
  );

  spiWordStore store (
    .aclk, .aresetn,
    .storeWrite, .storeSelect, .storeData,
    .shiftDone,
    .word0, .word1,
    .pending0, .pending1,
    .slotsCleared
  );

  spiShifter shifter (
    .aclk, .aresetn,
    .pending0, .pending1,
    .word0, .word1,
    .busy, .shiftDone,
    .serialClk, .serialData,
    .load0, .load1
  );

endmodule

// File: design/spiShifter.sv
// serial shifter with clock divider; sends a pending word MSB first between a falling and rising load line
`timescale 1ns/1ps

module spiShifter
  import spiWriterPkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  input  logic    pending0,        // word 0 needs sending
  input  logic    pending1,        // word 1 needs sending
  input  axiDataT word0,
  input  axiDataT word1,
  output logic    busy,            // transfer in progress
  output logic    shiftDone,       // high during the last bit
  output logic    serialClk,
  output logic    serialData,
  output logic    load0,           // codec load, active low during shift
  output logic    load1            // second device load
);

  typedef enum logic [2:0] {
    stIdle    = 3'd0,              // wait for a pending word
    stStart   = 3'd1,              // first clock edge
    stClkLow  = 3'd2,
    stClkHigh = 3'd3,
    stEnd1    = 3'd4,              // raise load line
    stEnd2    = 3'd5               // settle before next word
  } shiftStateT;

  logic [clkDivWidth-1:0] divCount;
  logic                   stepEn;  // one step per divider wrap
  shiftStateT             state;
  axiDataT                shiftReg;
  bitCountT               bitCount;
  logic                   longShift;  // current transfer is word 1

  assign stepEn     = (divCount == '0);
  assign serialData = shiftReg[axiDataWidth-1];  // MSB drives the pin

  //////////////////////////////
  // step divider
  //////////////////////////////
  // counts down from spiClockDivide-1, serial clock is half the step rate
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      divCount <= '0;
    else if (stepEn)
      divCount <= clkDivWidth'(spiClockDivide - 1);
    else
      divCount <= divCount - 1'b1;
  end

  //////////////////////////////
  // shift FSM
  //////////////////////////////
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state     <= stIdle;
      busy      <= 1'b0;
      shiftDone <= 1'b0;
      serialClk <= 1'b0;
      load0     <= 1'b1;           // loads idle high
      load1     <= 1'b1;
      longShift <= 1'b0;
      bitCount  <= '0;
      shiftReg  <= '0;
    end
    else if (stepEn)
    begin
      case (state)
        stIdle:
        begin
          serialClk <= 1'b0;
          if (pending0)            // word 0 wins a tie
          begin
            bitCount  <= bitCountT'(shortLen - 1);
            shiftReg  <= {word0[shortLen-1:0], {(axiDataWidth-shortLen){1'b0}}};
            load0     <= 1'b0;
            longShift <= 1'b0;
            busy      <= 1'b1;
            state     <= stStart;
          end
          else if (pending1)
          begin
            bitCount  <= bitCountT'(longLen - 1);
            shiftReg  <= word1;    // full word
            load1     <= 1'b0;
            longShift <= 1'b1;
            busy      <= 1'b1;
            state     <= stStart;
          end
        end

        stStart:
        begin
          serialClk <= 1'b1;       // receiver takes the MSB
          state     <= stClkHigh;
        end

        stClkLow:
        begin
          if (bitCount == '0)
            shiftDone <= 1'b1;     // last bit about to be clocked
          serialClk <= 1'b1;
          state     <= stClkHigh;
        end

        stClkHigh:
        begin
          serialClk <= 1'b0;       // data only moves with clock low
          if (bitCount == '0)
          begin
            shiftDone <= 1'b0;
            state     <= stEnd1;
          end
          else
          begin
            bitCount <= bitCount - 1'b1;
            shiftReg <= shiftReg << 1;  // next bit to the top
            state    <= stClkLow;
          end
        end

        stEnd1:
        begin
          busy <= 1'b0;
          // rising load latches the word in the device
          if (longShift)
            load1 <= 1'b1;
          else
            load0 <= 1'b1;
          state <= stEnd2;
        end

        stEnd2:
          state <= stIdle;
      endcase
    end
  end

endmodule

// File: design/spiWordStore.sv
// holds the two control words and their pending flags; flags drop when the shifter signals its last bit
`timescale 1ns/1ps

module spiWordStore
  import spiWriterPkg::*;
(
  input  logic    aclk,
  input  logic    aresetn,
  input  logic    storeWrite,      // commit strobe from the front end
  input  logic    storeSelect,     // high for word 1
  input  axiDataT storeData,
  input  logic    shiftDone,       // high during the last serial bit
  output axiDataT word0,
  output axiDataT word1,
  output logic    pending0,        // word 0 waiting to go out
  output logic    pending1,        // word 1 waiting to go out
  output logic    slotsCleared     // one cycle pulse at end of shift
);

  axiDataT word0Reg;
  axiDataT word1Reg;
  logic    pending0Reg;
  logic    pending1Reg;
  logic    shiftDoneQ;             // delayed copy for edge detect
  logic    doneEdge;

  assign doneEdge     = shiftDone & ~shiftDoneQ;  // leading edge only
  assign slotsCleared = doneEdge;

  assign word0    = word0Reg;
  assign word1    = word1Reg;
  assign pending0 = pending0Reg;
  assign pending1 = pending1Reg;

  //////////////////////////////
  // word registers and flags
  //////////////////////////////
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      word0Reg    <= '0;           // words read back as zero
      word1Reg    <= '0;
      pending0Reg <= 1'b0;
      pending1Reg <= 1'b0;
      shiftDoneQ  <= 1'b0;
    end
    else
    begin
      shiftDoneQ <= shiftDone;

      // only one word is ever outstanding, so clear both
      if (doneEdge)
      begin
        pending0Reg <= 1'b0;
        pending1Reg <= 1'b0;
      end

      if (storeWrite)
      begin
        if (storeSelect)
        begin
          word1Reg    <= storeData;
          pending1Reg <= 1'b1;
        end
        else
        begin
          word0Reg    <= storeData;
          pending0Reg <= 1'b1;
        end
      end
    end
  end

endmodule

// File: design/spiWriterPkg.sv
// shared widths, types, register map and shift lengths for the AXI4-Lite serial writer; import with spiWriterPkg::*
package spiWriterPkg;

  //////////////////////////////
  // AXI4-Lite bus
  //////////////////////////////
  localparam int axiAddrWidth = 16;                    // byte address bits
  localparam int axiDataWidth = 32;                    // data bus bits

  typedef logic [axiAddrWidth-1:0] axiAddrT;           // one AXI address
  typedef logic [axiDataWidth-1:0] axiDataT;           // one AXI data word
  typedef logic [1:0]              axiRespT;           // bresp / rresp code

  localparam axiRespT respOkay = 2'b00;                // only response this slave gives

  //////////////////////////////
  // register map
  //////////////////////////////
  // index taken from byte address bits 3:2
  localparam int regIndexLsb = 2;
  localparam int regIndexMsb = 3;

  localparam logic [regIndexMsb-regIndexLsb:0] regWord0  = 2'd0;  // offset 0, codec word
  localparam logic [regIndexMsb-regIndexLsb:0] regWord1  = 2'd1;  // offset 4, second device
  localparam logic [regIndexMsb-regIndexLsb:0] regStatus = 2'd2;  // offset 8, bit 0 busy

  //////////////////////////////
  // serial shifter
  //////////////////////////////
  localparam int spiClockDivide = 6;                   // system clocks per shifter step
  localparam int clkDivWidth    = $clog2(spiClockDivide);  // divider counter bits

  localparam int shortLen = 16;                        // word 0 shift length
  localparam int longLen  = 32;                        // word 1 shift length

  // down-counter of bits still to go, sized for the long word
  typedef logic [$clog2(longLen)-1:0] bitCountT;

endpackage

// File: dv/spiWriterTbTasks.svh
// AXI4-Lite bus, serial capture and compare tasks; included inside the serial writer testbench module

//////////////////////////////
// AXI4-Lite master
//////////////////////////////
// address and data offered together, bready raised after a random gap
task automatic axiWrite(input string name, input axiAddrT addr, input axiDataT data);
  int   waitCount;
  int   gap;
  logic awTake;
  logic wTake;
  logic bTake;
  waitCount = 0;
  gap       = $urandom_range(3, 0);          // cycles of bready held low
  bTake     = 1'b0;
  @(posedge aclk);
  #2;
  awaddr  = addr;
  wdata   = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;                            // waits here while wready is shut
  while (!bTake && waitCount < timeoutCycles)
  begin
    @(negedge aclk);
    awTake = awvalid & awready;              // transfers on the coming edge
    wTake  = wvalid & wready;
    bTake  = bvalid & bready;
    if (bTake)
      checkResp({name, " bresp"}, respOkay, bresp);
    @(posedge aclk);
    #2;
    awvalid = awvalid & ~awTake;
    wvalid  = wvalid & ~wTake;
    if (!awvalid && !wvalid && gap == 0)
      bready = ~bTake;
    else if (!awvalid && !wvalid)
      gap--;
    waitCount++;
  end
  if (!bTake)
  begin
    $display("timeout: %s write got no response", name);
    timeoutCount++;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
  end
endtask

// one read, then compare data and response
task automatic readCheck(input string name, input axiAddrT addr, input axiDataT expected);
  int   waitCount;
  int   gap;
  logic arTake;
  logic rTake;
  waitCount = 0;
  gap       = $urandom_range(3, 0);          // cycles of rready held low
  rTake     = 1'b0;
  @(posedge aclk);
  #2;
  araddr  = addr;
  arvalid = 1'b1;
  while (!rTake && waitCount < timeoutCycles)
  begin
    @(negedge aclk);
    arTake = arvalid & arready;
    rTake  = rvalid & rready;
    if (rTake)
    begin
      checkData(name, expected, rdata);
      checkResp({name, " rresp"}, respOkay, rresp);
    end
    @(posedge aclk);
    #2;
    arvalid = arvalid & ~arTake;
    if (!arvalid && gap == 0)
      rready = ~rTake;
    else if (!arvalid)
      gap--;
    waitCount++;
  end
  if (!rTake)
  begin
    $display("timeout: %s read returned no data", name);
    timeoutCount++;
    arvalid = 1'b0;
    rready  = 1'b0;
  end
endtask

//////////////////////////////
// serial side
//////////////////////////////
// one load pulse, bits taken on each rising serialClk
task automatic captureShift(input string name, output axiDataT bits, output int count,
                            output logic lineSel, output logic bothLow);
  int   waitCount;
  logic prevClk;
  bits      = '0;
  count     = 0;
  bothLow   = 1'b0;
  waitCount = 0;
  while (load0 && load1 && waitCount < timeoutCycles)
  begin
    @(negedge aclk);
    waitCount++;
  end
  lineSel = load0;                           // load0 still high, so load1 fell
  prevClk = serialClk;
  while (!(lineSel ? load1 : load0) && waitCount < timeoutCycles)
  begin
    @(negedge aclk);
    if (serialClk && !prevClk)
    begin
      bits = {bits[axiDataWidth-2:0], serialData};
      count++;
    end
    bothLow = bothLow | (!load0 && !load1);  // other line must stay high
    prevClk = serialClk;
    waitCount++;
  end
  if (waitCount >= timeoutCycles)
  begin
    $display("timeout: %s load line never fell and rose again", name);
    timeoutCount++;
  end
endtask

task automatic readBusyDuringShift(input string name);
  int waitCount;
  waitCount = 0;
  while (load0 && load1 && waitCount < timeoutCycles)
  begin
    @(negedge aclk);
    waitCount++;
  end
  readCheck({name, " status busy"}, statusAddr, 32'd1);
endtask

//////////////////////////////
// compares
//////////////////////////////
task automatic checkData(input string name, input axiDataT expected, input axiDataT actual);
  if (actual !== expected)
  begin
    $display("ERROR %s expected %h actual %h", name, expected, actual);
    errorCount++;
  end
endtask

task automatic checkResp(input string name, input axiRespT expected, input axiRespT actual);
  if (actual !== expected)
  begin
    $display("ERROR %s expected %b actual %b", name, expected, actual);
    errorCount++;
  end
endtask

task automatic checkBit(input string name, input logic expected, input logic actual);
  if (actual !== expected)
  begin
    $display("ERROR %s expected %b actual %b", name, expected, actual);
    errorCount++;
  end
endtask

// File: dv/spiWriterTb.sv
// testbench for the AXI4-Lite serial writer compiled from sim.f with spiWriterTb as top
`timescale 1ns/1ps

module spiWriterTb
  import spiWriterPkg::*;
();

  localparam int      timeoutCycles = 1000;      // aclk cycles allowed per wait loop
  localparam axiAddrT statusAddr    = 16'h0008;  // index 2 holds busy in bit 0

  logic    aclk, aresetn;
  axiAddrT awaddr, araddr;
  axiDataT wdata, rdata;
  axiRespT bresp, rresp;
  logic    awvalid, awready, wvalid, wready, bvalid, bready;
  logic    arvalid, arready, rvalid, rready;
  logic    serialClk, serialData, load0, load1;
  int      errorCount;                           // wrong values seen
  int      timeoutCount;                         // waits that ran out

  // one write and the serial word it should produce
  typedef struct {
    string   name;
    axiAddrT addr;
    axiDataT data;
    axiDataT expBits;                            // bits seen on serialData MSB first
    int      expLen;
  } stimT;

  stimT stimTable [6] = '{
    '{"word0 pattern", 16'h0000, 32'hdead_a5c3, 32'h0000_a5c3, 16},
    '{"word1 full",    16'h0004, 32'h8123_4567, 32'h8123_4567, 32},
    '{"word0 ones",    16'h0000, 32'h0000_ffff, 32'h0000_ffff, 16},
    '{"word1 alt",     16'h0004, 32'h5555_aaaa, 32'h5555_aaaa, 32},
    '{"word1 again",   16'h0004, 32'h0f0f_f0f1, 32'h0f0f_f0f1, 32},  // word 0 untouched
    '{"word0 low",     16'h0000, 32'h1234_0001, 32'h0000_0001, 16}   // upper half not shifted
  };

  axilSpiWriter DUT (.*);

  `include "spiWriterTbTasks.svh"

  //////////////////////////////
  // clock
  //////////////////////////////
  initial
  begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;                    // 40 ns period
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial
  begin
    axiDataT shadow [2];                         // last value written to each word
    axiDataT bits;
    int      count;
    logic    lineSel;                            // high when load1 was the line that fell
    logic    bothLow;
    logic    lineExp;                            // offset 4 goes out on load1
    void'($urandom(5734));
    errorCount   = 0;
    timeoutCount = 0;
    shadow[0]    = '0;
    shadow[1]    = '0;
    aresetn      = 1'b0;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    repeat (4) @(posedge aclk);
    #2;
    aresetn = 1'b1;

    // idle values straight out of reset
    @(negedge aclk);
    checkBit("reset load0", 1'b1, load0);
    checkBit("reset load1", 1'b1, load1);
    readCheck("reset status", statusAddr, '0);
    readCheck("reset word0", 16'h0000, '0);
    readCheck("reset word1", 16'h0004, '0);

    for (int i = 0; i < 6; i++)
    begin
      lineExp = (stimTable[i].addr == 16'h0004);
      axiWrite(stimTable[i].name, stimTable[i].addr, stimTable[i].data);
      if (lineExp)
        shadow[1] = stimTable[i].data;
      else
        shadow[0] = stimTable[i].data;
      fork
        captureShift(stimTable[i].name, bits, count, lineSel, bothLow);
        readBusyDuringShift(stimTable[i].name);  // status while the load line is low
      join
      checkData({stimTable[i].name, " bits"}, stimTable[i].expBits, bits);
      checkData({stimTable[i].name, " length"}, axiDataT'(stimTable[i].expLen),
                axiDataT'(count));
      checkBit({stimTable[i].name, " load line"}, lineExp, lineSel);
      checkBit({stimTable[i].name, " both loads low"}, 1'b0, bothLow);
      readCheck({stimTable[i].name, " status after"}, statusAddr, '0);
      readCheck({stimTable[i].name, " word0 readback"}, 16'h0000, shadow[0]);
      readCheck({stimTable[i].name, " word1 readback"}, 16'h0004, shadow[1]);
    end

    // back-to-back writes with each data beat taken as soon as wready reopens
    fork
      begin
        for (int i = 0; i < 6; i++)
          axiWrite({stimTable[i].name, " burst"}, stimTable[i].addr, stimTable[i].data);
      end
      begin
        for (int j = 0; j < 6; j++)
        begin
          captureShift({stimTable[j].name, " burst"}, bits, count, lineSel, bothLow);
          checkData({stimTable[j].name, " burst bits"}, stimTable[j].expBits, bits);
          checkData({stimTable[j].name, " burst length"}, axiDataT'(stimTable[j].expLen),
                    axiDataT'(count));
          checkBit({stimTable[j].name, " burst load line"},
                   stimTable[j].addr == 16'h0004, lineSel);
          checkBit({stimTable[j].name, " burst both loads low"}, 1'b0, bothLow);
        end
      end
    join
    readCheck("burst word0 readback", 16'h0000, shadow[0]);
    readCheck("burst word1 readback", 16'h0004, shadow[1]);

    $display("errors: %0d wrong values, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: sim.f
+incdir+dv
design/spiWriterPkg.sv
design/axilRegFront.sv
design/spiWordStore.sv
design/spiShifter.sv
design/axilSpiWriter.sv
dv/spiWriterTb.sv
